//--- source/iob_bus_pkg.sv
// ==========================================================
// iob native bus package
// widths and request/response payloads of the IOb port
// ==========================================================
`default_nettype none

package iob_bus_pkg;

   // byte address of a 32-bit word access
   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // zero strobes mark a read
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } iob_req_t;

   // ready acknowledges the request, rvalid carries read data
   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } iob_resp_t;

endpackage

`default_nettype wire

//--- source/axil_bus_pkg.sv
// ==========================================================
// axi4-lite bus package
// widths, response codes and channel payloads
// ==========================================================
`default_nettype none

package axil_bus_pkg;

   localparam int AXIL_ADDR_W = 12;
   localparam int AXIL_DATA_W = 32;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // words in the register file
   localparam int REG_DEPTH = 16;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0]   data;
      logic [AXIL_DATA_W/8-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axil_b_t;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      logic [1:0]             resp;
   } axil_r_t;

endpackage

`default_nettype wire

//--- source/iob_iob2axil.sv
// ==========================================================
// iob to axi4-lite bridge
// one access at a time, writes acknowledged on the B response
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module iob_iob2axil (
   input  wire                       clk_i,
   input  wire                       reset_i,
   // iob subordinate side
   input  wire iob_bus_pkg::iob_req_t iob_req_i,
   input  wire                       iob_rready_i,
   output iob_bus_pkg::iob_resp_t    iob_resp_o,
   // axi4-lite manager side
   output logic                      axil_awvalid_o,
   input  wire                       axil_awready_i,
   output axil_bus_pkg::axil_aw_t    axil_aw_o,
   output logic                      axil_wvalid_o,
   input  wire                       axil_wready_i,
   output axil_bus_pkg::axil_w_t     axil_w_o,
   input  wire                       axil_bvalid_i,
   output logic                      axil_bready_o,
   input  wire axil_bus_pkg::axil_b_t axil_b_i,
   output logic                      axil_arvalid_o,
   input  wire                       axil_arready_i,
   output axil_bus_pkg::axil_ar_t    axil_ar_o,
   input  wire                       axil_rvalid_i,
   output logic                      axil_rready_o,
   input  wire axil_bus_pkg::axil_r_t axil_r_i,
   output logic                      bus_err_o
);

   import iob_bus_pkg::*;
   import axil_bus_pkg::*;

   logic is_write;
   logic aw_done;
   logic wvalid_q;
   logic err_q;
   logic aw_xfer;
   logic w_xfer;
   logic b_xfer;
   logic ar_xfer;
   logic r_xfer;

   assign is_write = (iob_req_i.wstrb != {STRB_W{1'b0}});

   assign aw_xfer = axil_awvalid_o & axil_awready_i;
   assign w_xfer  = axil_wvalid_o & axil_wready_i;
   assign b_xfer  = axil_bvalid_i & axil_bready_o;
   assign ar_xfer = axil_arvalid_o & axil_arready_i;
   assign r_xfer  = axil_rvalid_i & axil_rready_o;

   // address phase drops once the address is taken
   assign axil_awvalid_o = iob_req_i.valid & is_write & ~aw_done;
   assign axil_aw_o.addr = iob_req_i.addr;

   assign axil_wvalid_o = wvalid_q;
   assign axil_w_o.data = iob_req_i.wdata;
   assign axil_w_o.strb = iob_req_i.wstrb;

   // address and data both sent, waiting on the response
   assign axil_bready_o = aw_done & ~wvalid_q;

   assign axil_arvalid_o = iob_req_i.valid & ~is_write;
   assign axil_ar_o.addr = iob_req_i.addr;

   assign axil_rready_o = iob_rready_i;

   assign iob_resp_o.ready  = b_xfer | ar_xfer;
   assign iob_resp_o.rvalid = axil_rvalid_i;
   assign iob_resp_o.rdata  = axil_r_i.data;

   assign bus_err_o = err_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         aw_done  <= 1'b0;
         wvalid_q <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         if (aw_xfer) begin
            aw_done <= 1'b1;
         end else if (b_xfer) begin
            aw_done <= 1'b0;
         end
         if (aw_xfer) begin
            wvalid_q <= 1'b1;
         end else if (w_xfer) begin
            wvalid_q <= 1'b0;
         end
         err_q <= (b_xfer & (axil_b_i.resp != RESP_OKAY))
                | (r_xfer & (axil_r_i.resp != RESP_OKAY));
      end
   end

   // no read address while a write is still in flight
   a_aw_ar_excl : assert property (@(posedge clk_i) disable iff (reset_i)
      !(axil_arvalid_o && (axil_awvalid_o || aw_done)))
      else $error("arvalid high during a write");

   // write data held until the register file takes it
   a_w_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      axil_wvalid_o && !axil_wready_i |=> axil_wvalid_o && $stable(axil_w_o))
      else $error("w channel changed before wready");

endmodule

`default_nettype wire

//--- source/axil_regfile.sv
// ==========================================================
// axi4-lite register file
// 16 byte-writable words, SLVERR outside the register range
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module axil_regfile (
   input  wire                        clk_i,
   input  wire                        reset_i,
   // write address
   input  wire                        axil_awvalid_i,
   output logic                       axil_awready_o,
   input  wire axil_bus_pkg::axil_aw_t axil_aw_i,
   // write data
   input  wire                        axil_wvalid_i,
   output logic                       axil_wready_o,
   input  wire axil_bus_pkg::axil_w_t  axil_w_i,
   // write response
   output logic                       axil_bvalid_o,
   input  wire                        axil_bready_i,
   output axil_bus_pkg::axil_b_t      axil_b_o,
   // read address
   input  wire                        axil_arvalid_i,
   output logic                       axil_arready_o,
   input  wire axil_bus_pkg::axil_ar_t axil_ar_i,
   // read data
   output logic                       axil_rvalid_o,
   input  wire                        axil_rready_i,
   output axil_bus_pkg::axil_r_t      axil_r_o
);

   import axil_bus_pkg::*;

   logic [AXIL_DATA_W-1:0] mem [REG_DEPTH];

   logic                   aw_held;
   logic [AXIL_ADDR_W-1:0] aw_addr_q;
   logic                   bvalid_q;
   axil_b_t                b_q;
   logic                   rvalid_q;
   axil_r_t                r_q;

   logic aw_xfer;
   logic w_xfer;
   logic ar_xfer;
   logic wr_in_range;
   logic rd_in_range;

   // one write in flight, next address only after the response
   assign axil_awready_o = ~aw_held & ~bvalid_q;
   assign axil_wready_o  = aw_held;
   // no new read while the current data is stalled
   assign axil_arready_o = ~rvalid_q | axil_rready_i;

   assign aw_xfer = axil_awvalid_i & axil_awready_o;
   assign w_xfer  = axil_wvalid_i & axil_wready_o;
   assign ar_xfer = axil_arvalid_i & axil_arready_o;

   assign wr_in_range = (aw_addr_q < AXIL_ADDR_W'(REG_DEPTH * 4));
   assign rd_in_range = (axil_ar_i.addr < AXIL_ADDR_W'(REG_DEPTH * 4));

   assign axil_bvalid_o = bvalid_q;
   assign axil_b_o      = b_q;
   assign axil_rvalid_o = rvalid_q;
   assign axil_r_o      = r_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         aw_held  <= 1'b0;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (aw_xfer) begin
            aw_held <= 1'b1;
         end else if (w_xfer) begin
            aw_held <= 1'b0;
         end
         if (w_xfer) begin
            bvalid_q <= 1'b1;
         end else if (axil_bready_i) begin
            bvalid_q <= 1'b0;
         end
         if (ar_xfer) begin
            rvalid_q <= 1'b1;
         end else if (axil_rready_i) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // address latch and write response
   always_ff @(posedge clk_i) begin
      if (aw_xfer) begin
         aw_addr_q <= axil_aw_i.addr;
      end
      if (w_xfer) begin
         b_q.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
      end
   end

   // byte merge, word index from address bits 5:2
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int j = 0; j < REG_DEPTH; j++) begin
            mem[j] <= '0;
         end
      end else if (w_xfer && wr_in_range) begin
         for (int i = 0; i < AXIL_DATA_W / 8; i++) begin
            if (axil_w_i.strb[i]) begin
               mem[aw_addr_q[5:2]][8*i +: 8] <= axil_w_i.data[8*i +: 8];
            end
         end
      end
   end

   // out of range reads return zero
   always_ff @(posedge clk_i) begin
      if (ar_xfer) begin
         r_q.data <= rd_in_range ? mem[axil_ar_i.addr[5:2]] : '0;
         r_q.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      end
   end

   a_b_hold : assert property (@(posedge clk_i) disable iff (reset_i)
      axil_bvalid_o && !axil_bready_i |=> axil_bvalid_o && $stable(axil_b_o))
      else $error("b channel changed before bready");

   a_r_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      axil_rvalid_o && !axil_rready_i |=> axil_rvalid_o && $stable(axil_r_o))
      else $error("r channel changed while stalled");

endmodule

`default_nettype wire

//--- source/iob_axil_system.sv
// ==========================================================
// iob to axi4-lite subsystem
// bridge driving the register file
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module iob_axil_system (
   input  wire                        clk_i,
   input  wire                        reset_i,
   input  wire iob_bus_pkg::iob_req_t iob_req_i,
   input  wire                        iob_rready_i,
   output iob_bus_pkg::iob_resp_t     iob_resp_o,
   output logic                       bus_err_o
);

   import axil_bus_pkg::*;

   // axi4-lite channels between bridge and register file
   logic     axil_awvalid;
   logic     axil_awready;
   axil_aw_t axil_aw;
   logic     axil_wvalid;
   logic     axil_wready;
   axil_w_t  axil_w;
   logic     axil_bvalid;
   logic     axil_bready;
   axil_b_t  axil_b;
   logic     axil_arvalid;
   logic     axil_arready;
   axil_ar_t axil_ar;
   logic     axil_rvalid;
   logic     axil_rready;
   axil_r_t  axil_r;

   iob_iob2axil u_bridge (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .iob_req_i      (iob_req_i),
      .iob_rready_i   (iob_rready_i),
      .iob_resp_o     (iob_resp_o),
      .axil_awvalid_o (axil_awvalid),
      .axil_awready_i (axil_awready),
      .axil_aw_o      (axil_aw),
      .axil_wvalid_o  (axil_wvalid),
      .axil_wready_i  (axil_wready),
      .axil_w_o       (axil_w),
      .axil_bvalid_i  (axil_bvalid),
      .axil_bready_o  (axil_bready),
      .axil_b_i       (axil_b),
      .axil_arvalid_o (axil_arvalid),
      .axil_arready_i (axil_arready),
      .axil_ar_o      (axil_ar),
      .axil_rvalid_i  (axil_rvalid),
      .axil_rready_o  (axil_rready),
      .axil_r_i       (axil_r),
      .bus_err_o      (bus_err_o)
   );

   axil_regfile u_regfile (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .axil_awvalid_i (axil_awvalid),
      .axil_awready_o (axil_awready),
      .axil_aw_i      (axil_aw),
      .axil_wvalid_i  (axil_wvalid),
      .axil_wready_o  (axil_wready),
      .axil_w_i       (axil_w),
      .axil_bvalid_o  (axil_bvalid),
      .axil_bready_i  (axil_bready),
      .axil_b_o       (axil_b),
      .axil_arvalid_i (axil_arvalid),
      .axil_arready_o (axil_arready),
      .axil_ar_i      (axil_ar),
      .axil_rvalid_o  (axil_rvalid),
      .axil_rready_i  (axil_rready),
      .axil_r_o       (axil_r)
   );

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
// ==========================================================
// testbench clock source, free running from time zero
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb/iob_axil_system_tb.sv
// ==========================================================
// iob to axi4-lite subsystem testbench
// directed tests against a reference model of the register file
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module iob_axil_system_tb;

   import iob_bus_pkg::*;
   import axil_bus_pkg::*;

   localparam int TIMEOUT = 50;
   localparam int WRITE_CYCLES = 3;

   logic              clk;
   logic              reset_i;
   iob_req_t          req;
   logic              rready;
   iob_resp_t         resp;
   logic              bus_err;
   logic [DATA_W-1:0] model [REG_DEPTH];
   int                errors;
   int                checks;
   int                test_start;

   clock_gen #(.PERIOD_NS(40)) u_clk (.clk_o(clk));

   iob_axil_system dut (
      .clk_i        (clk),
      .reset_i      (reset_i),
      .iob_req_i    (req),
      .iob_rready_i (rready),
      .iob_resp_o   (resp),
      .bus_err_o    (bus_err)
   );

   task automatic finish_run();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] actual,
                             input logic [DATA_W-1:0] expected);
      checks++;
      if (actual !== expected) begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic check_err(input string name, input logic actual, input logic expected);
      checks++;
      if (actual !== expected) begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic check_cycles(input string name, input int actual, input int expected);
      checks++;
      if (actual != expected) begin
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         errors++;
      end
   endtask

   // byte lanes picked by the strobes take the new data
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] mask;
      for (int i = 0; i < STRB_W; i++) begin
         mask[8*i +: 8] = {8{strb[i]}};
      end
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   // cycles counted from the first cycle the request is valid
   task automatic wait_ready(output int cycles);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!resp.ready && n < TIMEOUT);
      cycles = n;
      if (!resp.ready) begin
         $display("timeout: request was never acknowledged");
         errors++;
         finish_run();
      end
   endtask

   task automatic wait_rvalid();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!resp.rvalid && n < TIMEOUT);
      if (!resp.rvalid) begin
         $display("timeout: read data never became valid");
         errors++;
         finish_run();
      end
   endtask

   task automatic send_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                               input logic [STRB_W-1:0] wstrb, output int cycles);
      @(posedge clk);
      req <= '{1'b1, addr, wdata, wstrb};
      wait_ready(cycles);
      @(posedge clk);
      req <= '0;
   endtask

   task automatic iob_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] wstrb, input logic exp_err);
      int cycles;
      send_request(addr, wdata, wstrb, cycles);
      check_cycles("write latency", cycles, WRITE_CYCLES);
      // error pulse follows the B transfer by one cycle
      @(negedge clk);
      check_err("bus_err_o", bus_err, exp_err);
   endtask

   task automatic iob_read(input logic [ADDR_W-1:0] addr, input logic exp_err,
                           output logic [DATA_W-1:0] data);
      int cycles;
      send_request(addr, '0, '0, cycles);
      wait_rvalid();
      data = resp.rdata;
      @(negedge clk);
      check_err("bus_err_o", bus_err, exp_err);
   endtask

   task automatic report_test(input string name);
      $display("test %s: %s (%0d errors)", name,
               (errors == test_start) ? "ok" : "FAILED", errors - test_start);
   endtask

   // every word reads zero straight out of reset
   task automatic test_reset_and_full();
      logic [DATA_W-1:0] rd;
      for (int i = 0; i < REG_DEPTH; i++) begin
         iob_read(ADDR_W'(i * 4), 1'b0, rd);
         check_data("rdata", rd, '0);
         model[i] = '0;
      end
      for (int i = 0; i < REG_DEPTH; i++) begin
         model[i] = $urandom();
         iob_write(ADDR_W'(i * 4), model[i], 4'hf, 1'b0);
      end
      for (int i = 0; i < REG_DEPTH; i++) begin
         iob_read(ADDR_W'(i * 4), 1'b0, rd);
         check_data("rdata", rd, model[i]);
      end
   endtask

   task automatic test_partial_strobes();
      logic [STRB_W-1:0] strb_list [8];
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] wd;
      int                idx;
      strb_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0101, 4'b1010};
      for (int k = 0; k < 8; k++) begin
         idx = $urandom_range(REG_DEPTH - 1);
         wd  = $urandom();
         iob_write(ADDR_W'(idx * 4), wd, strb_list[k], 1'b0);
         model[idx] = merge_bytes(model[idx], wd, strb_list[k]);
         iob_read(ADDR_W'(idx * 4), 1'b0, rd);
         check_data("rdata", rd, model[idx]);
      end
   endtask

   task automatic test_write_range_error();
      logic [DATA_W-1:0] rd;
      iob_write(12'h040, 32'hdead_beef, 4'hf, 1'b1);
      iob_write(12'h100, 32'h1234_5678, 4'h3, 1'b1);
      iob_write(12'hffc, 32'hcafe_f00d, 4'hf, 1'b1);
      for (int i = 0; i < REG_DEPTH; i++) begin
         iob_read(ADDR_W'(i * 4), 1'b0, rd);
         check_data("rdata", rd, model[i]);
      end
   endtask

   task automatic test_read_range_error();
      logic [DATA_W-1:0] rd;
      iob_read(12'h040, 1'b1, rd);
      check_data("rdata", rd, '0);
      iob_read(12'h200, 1'b1, rd);
      check_data("rdata", rd, '0);
      iob_read(12'hffc, 1'b1, rd);
      check_data("rdata", rd, '0);
   endtask

   task automatic test_read_backpressure();
      logic [DATA_W-1:0] held;
      int                cycles;
      @(posedge clk);
      rready <= 1'b0;
      send_request(12'h00c, '0, '0, cycles);
      wait_rvalid();
      held = resp.rdata;
      check_data("rdata", held, model[3]);
      // second read waits behind the stalled data
      @(posedge clk);
      req <= '{1'b1, 12'h01c, '0, '0};
      repeat (4) begin
         @(negedge clk);
         check_err("rvalid", resp.rvalid, 1'b1);
         check_data("rdata", resp.rdata, held);
         check_err("ready", resp.ready, 1'b0);
      end
      @(posedge clk);
      rready <= 1'b1;
      wait_ready(cycles);
      @(posedge clk);
      req <= '0;
      wait_rvalid();
      check_data("rdata", resp.rdata, model[7]);
   endtask

   task automatic test_random_ops();
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] wd;
      logic [STRB_W-1:0] strb;
      int                idx;
      for (int k = 0; k < 200; k++) begin
         idx = $urandom_range(REG_DEPTH - 1);
         if ($urandom_range(1) == 1) begin
            wd   = $urandom();
            strb = STRB_W'($urandom_range(15, 1));
            iob_write(ADDR_W'(idx * 4), wd, strb, 1'b0);
            model[idx] = merge_bytes(model[idx], wd, strb);
         end else begin
            iob_read(ADDR_W'(idx * 4), 1'b0, rd);
            check_data("rdata", rd, model[idx]);
         end
      end
   endtask

   initial begin
      req        = '0;
      rready     = 1'b1;
      reset_i    = 1'b1;
      errors     = 0;
      checks     = 0;
      test_start = 0;
      void'($urandom(32'h47be_aacb));
      repeat (5) @(posedge clk);
      reset_i <= 1'b0;

      test_start = errors;
      test_reset_and_full();
      report_test("reset values and full-strobe writes");
      test_start = errors;
      test_partial_strobes();
      report_test("partial strobes");
      test_start = errors;
      test_write_range_error();
      report_test("out of range write");
      test_start = errors;
      test_read_range_error();
      report_test("out of range read");
      test_start = errors;
      test_read_backpressure();
      report_test("read back-pressure");
      test_start = errors;
      test_random_ops();
      report_test("random operations");

      finish_run();
   end

endmodule

`default_nettype wire

//--- flist.f
source/iob_bus_pkg.sv
source/axil_bus_pkg.sv
source/iob_iob2axil.sv
source/axil_regfile.sv
source/iob_axil_system.sv
tb/clock_gen.sv
tb/iob_axil_system_tb.sv
